/* logic/axi_types_pkg.sv */
/*
 * AXI4 types for the core memory subsystem, with AXI5 atomic (atop) encoding.
 * Holds bus widths, burst/response codes, atop fields and the channel structs
 * that the adapter and the memory exchange. IDs, QoS, cache and protection
 * signals are not carried. Refer to items as axi_types_pkg::name.
 */
`default_nettype none

package axi_types_pkg;

  localparam int unsigned AddrWidth = 32;  // byte address
  localparam int unsigned DataWidth = 32;  // one word per beat
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned LenWidth  = 8;   // beats minus one
  localparam int unsigned AtopWidth = 6;

  localparam logic [1:0] BURST_INCR = 2'b01;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_EXOKAY = 2'b01;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // atop[5:4] type, atop[3] endianness, atop[2:0] operation
  localparam logic [1:0] ATOP_ATOMICLOAD = 2'b10;
  localparam logic       ATOP_LITTLE_END = 1'b0;
  localparam logic [5:0] ATOP_ATOMICSWAP = 6'b110000;  // full code
  localparam logic [2:0] ATOP_ADD  = 3'b000;
  localparam logic [2:0] ATOP_CLR  = 3'b001;
  localparam logic [2:0] ATOP_EOR  = 3'b010;
  localparam logic [2:0] ATOP_SET  = 3'b011;
  localparam logic [2:0] ATOP_SMAX = 3'b100;
  localparam logic [2:0] ATOP_SMIN = 3'b101;
  localparam logic [2:0] ATOP_UMAX = 3'b110;
  localparam logic [2:0] ATOP_UMIN = 3'b111;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
    logic [2:0]           size;
    logic [1:0]           burst;
    logic [AtopWidth-1:0] atop;
  } axi_aw_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
    logic [2:0]           size;
    logic [1:0]           burst;
  } axi_ar_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    logic                 last;
  } axi_w_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [1:0]           resp;
    logic                 last;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

  // manager side of the bus
  typedef struct packed {
    axi_aw_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
    axi_ar_t ar;
    logic    ar_valid;
    logic    r_ready;
  } axi_req_t;

  // subordinate side of the bus
  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    logic    w_ready;
    axi_b_t  b;
    logic    b_valid;
    axi_r_t  r;
    logic    r_valid;
  } axi_resp_t;

endpackage

`default_nettype wire

/* logic/core_mem_pkg.sv */
/*
 * Core-side request/response types for the memory subsystem.
 * A request carries a load, store or AMO; a response carries one read beat.
 * Widths follow the AXI data path in axi_types_pkg.
 */
`default_nettype none

package core_mem_pkg;

  typedef enum logic [3:0] {
    NONE = 4'h0,
    SWAP = 4'h1,
    ADD  = 4'h2,
    AND  = 4'h3,
    OR   = 4'h4,
    XOR  = 4'h5,
    MAX  = 4'h6,
    MAXU = 4'h7,
    MIN  = 4'h8,
    MINU = 4'h9,
    LR   = 4'hA,
    SC   = 4'hB
  } amo_op_t;

  typedef struct packed {
    logic [axi_types_pkg::AddrWidth-1:0] addr;
    logic                                write;  // AMOs are sent as writes
    amo_op_t                             amo;
    logic [axi_types_pkg::DataWidth-1:0] data;
    logic [axi_types_pkg::StrbWidth-1:0] strb;
    logic [axi_types_pkg::LenWidth-1:0]  rlen;   // read beats minus one
  } core_req_t;

  typedef struct packed {
    logic [axi_types_pkg::DataWidth-1:0] data;
    logic                                error;
    logic                                last;
  } core_rsp_t;

  typedef struct packed {
    logic [axi_types_pkg::DataWidth-1:0] data;
    logic [axi_types_pkg::StrbWidth-1:0] strb;
  } write_entry_t;

endpackage

`default_nettype wire

/* logic/write_buffer.sv */
/*
 * Small synchronous FIFO for write data and strobes.
 * Push and pop may happen in the same cycle; data_o shows the head entry.
 * The producer must not push while full_o is high.
 */
`default_nettype none
`timescale 1ns/10ps

module write_buffer #(
  parameter int unsigned Depth = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       push_i,
  input  core_mem_pkg::write_entry_t data_i,
  input  logic                       pop_i,
  output core_mem_pkg::write_entry_t data_o,
  output logic                       full_o,
  output logic                       empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  core_mem_pkg::write_entry_t entries_q [Depth];
  logic [PtrWidth-1:0]        rd_ptr_q, wr_ptr_q;
  logic [CntWidth-1:0]        count_q;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + PtrWidth'(1);  // wrap at depth
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_i)  rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + CntWidth'(1);
        2'b01:   count_q <= count_q - CntWidth'(1);
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) entries_q[wr_ptr_q] <= data_i;
  end

  assign data_o  = entries_q[rd_ptr_q];
  assign full_o  = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0);

endmodule

`default_nettype wire

/* logic/core_axi_adapter.sv */
/*
 * Core request port to AXI4 manager adapter.
 * Loads become INCR read bursts, stores and AMOs become single-beat writes
 * whose data is queued in a write buffer. AMOs are encoded in AW atop.
 * B responses are always accepted and dropped; R beats go to the core.
 */
`default_nettype none
`timescale 1ns/10ps

module core_axi_adapter #(
  parameter int unsigned WriteDepth = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  core_mem_pkg::core_req_t  core_req_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  output core_mem_pkg::core_rsp_t  core_rsp_o,
  output logic                     rsp_valid_o,
  input  logic                     rsp_ready_i,
  output axi_types_pkg::axi_req_t  axi_req_o,
  input  axi_types_pkg::axi_resp_t axi_resp_i
);

  localparam logic [2:0] WordSize   = 3'($clog2(axi_types_pkg::StrbWidth));
  localparam logic [2:0] AtopLoadLe = {axi_types_pkg::ATOP_ATOMICLOAD,
                                       axi_types_pkg::ATOP_LITTLE_END};

  logic                                write_full;
  logic                                write_empty;
  core_mem_pkg::write_entry_t          write_in;
  core_mem_pkg::write_entry_t          write_out;
  logic [axi_types_pkg::AtopWidth-1:0] atop;

  // RISC-V AMOs map onto atomic loads, so the old value comes back on R
  always_comb begin
    write_in.data = core_req_i.data;
    write_in.strb = core_req_i.strb;
    unique case (core_req_i.amo)
      core_mem_pkg::SWAP: atop = axi_types_pkg::ATOP_ATOMICSWAP;
      core_mem_pkg::ADD:  atop = {AtopLoadLe, axi_types_pkg::ATOP_ADD};
      core_mem_pkg::AND: begin
        write_in.data = ~core_req_i.data;  // and is a clear of the inverted operand
        atop          = {AtopLoadLe, axi_types_pkg::ATOP_CLR};
      end
      core_mem_pkg::OR:   atop = {AtopLoadLe, axi_types_pkg::ATOP_SET};
      core_mem_pkg::XOR:  atop = {AtopLoadLe, axi_types_pkg::ATOP_EOR};
      core_mem_pkg::MAX:  atop = {AtopLoadLe, axi_types_pkg::ATOP_SMAX};
      core_mem_pkg::MAXU: atop = {AtopLoadLe, axi_types_pkg::ATOP_UMAX};
      core_mem_pkg::MIN:  atop = {AtopLoadLe, axi_types_pkg::ATOP_SMIN};
      core_mem_pkg::MINU: atop = {AtopLoadLe, axi_types_pkg::ATOP_UMIN};
      default:            atop = '0;  // none, lr and sc
    endcase
  end

  write_buffer #(
    .Depth   ( WriteDepth                                     )
  ) i_write_buffer (
    .clk_i,
    .rst_i,
    .push_i  ( axi_req_o.aw_valid & axi_resp_i.aw_ready      ),
    .data_i  ( write_in                                       ),
    .pop_i   ( axi_req_o.w_valid & axi_resp_i.w_ready        ),
    .data_o  ( write_out                                      ),
    .full_o  ( write_full                                     ),
    .empty_o ( write_empty                                    )
  );

  assign axi_req_o.aw.addr  = core_req_i.addr;
  assign axi_req_o.aw.len   = '0;  // writes are single beat
  assign axi_req_o.aw.size  = WordSize;
  assign axi_req_o.aw.burst = axi_types_pkg::BURST_INCR;
  assign axi_req_o.aw.atop  = atop;
  assign axi_req_o.aw_valid = req_valid_i & core_req_i.write & ~write_full;

  assign axi_req_o.w.data   = write_out.data;
  assign axi_req_o.w.strb   = write_out.strb;
  assign axi_req_o.w.last   = 1'b1;
  assign axi_req_o.w_valid  = ~write_empty;

  assign axi_req_o.b_ready  = 1'b1;  // write responses are swallowed

  assign axi_req_o.ar.addr  = core_req_i.addr;
  assign axi_req_o.ar.len   = core_req_i.rlen;
  assign axi_req_o.ar.size  = WordSize;
  assign axi_req_o.ar.burst = axi_types_pkg::BURST_INCR;
  assign axi_req_o.ar_valid = req_valid_i & ~core_req_i.write;

  assign core_rsp_o.data    = axi_resp_i.r.data;
  assign core_rsp_o.error   = ~(axi_resp_i.r.resp inside {axi_types_pkg::RESP_OKAY,
                                                          axi_types_pkg::RESP_EXOKAY});
  assign core_rsp_o.last    = axi_resp_i.r.last;
  assign rsp_valid_o        = axi_resp_i.r_valid;
  assign axi_req_o.r_ready  = rsp_ready_i;

  assign req_ready_o = (axi_req_o.ar_valid & axi_resp_i.ar_ready)
                     | (axi_req_o.aw_valid & axi_resp_i.aw_ready);

endmodule

`default_nettype wire

/* logic/axi_atomic_mem.sv */
/*
 * AXI4 subordinate word memory with AXI5 atomic support.
 * Serves INCR read bursts, single-beat strobed writes and atomic loads.
 * One transaction at a time; AR wins over AW when both arrive while idle.
 * Words at or beyond MemWords answer SLVERR and leave the array unchanged.
 */
`default_nettype none
`timescale 1ns/10ps

module axi_atomic_mem #(
  parameter int unsigned MemWords = 256
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  axi_types_pkg::axi_req_t  axi_req_i,
  output axi_types_pkg::axi_resp_t axi_resp_o
);

  localparam int unsigned DW          = axi_types_pkg::DataWidth;
  localparam int unsigned OffsetWidth = $clog2(axi_types_pkg::StrbWidth);
  localparam int unsigned WordWidth   = axi_types_pkg::AddrWidth - OffsetWidth;
  localparam int unsigned IdxWidth    = (MemWords > 1) ? $clog2(MemWords) : 1;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    WAIT_W,
    WRITE_RESP,
    ATOMIC_RESP
  } state_e;

  logic [DW-1:0]                       mem_q [MemWords];
  state_e                              state_q, state_d;
  logic [WordWidth-1:0]                rd_word_q, wr_word_q;
  logic [axi_types_pkg::LenWidth-1:0]  rd_len_q, beat_cnt_q;
  logic [axi_types_pkg::AtopWidth-1:0] atop_q;
  logic [DW-1:0]                       old_q;
  logic                                err_q;
  logic                                r_pend_q, b_pend_q;  // atomic R and B still owed

  logic          ar_hs, aw_hs, w_hs, r_hs, b_hs;
  logic          rd_in_range, wr_in_range, rd_last, is_atomic;
  logic [DW-1:0] rd_data, wr_old, amo_result;

  assign ar_hs = axi_req_i.ar_valid & axi_resp_o.ar_ready;
  assign aw_hs = axi_req_i.aw_valid & axi_resp_o.aw_ready;
  assign w_hs  = axi_req_i.w_valid  & axi_resp_o.w_ready;
  assign r_hs  = axi_resp_o.r_valid & axi_req_i.r_ready;
  assign b_hs  = axi_resp_o.b_valid & axi_req_i.b_ready;

  assign rd_in_range = (rd_word_q < WordWidth'(MemWords));
  assign wr_in_range = (wr_word_q < WordWidth'(MemWords));
  assign rd_last     = (beat_cnt_q == rd_len_q);
  assign is_atomic   = (atop_q != '0);
  assign rd_data     = rd_in_range ? mem_q[rd_word_q[IdxWidth-1:0]] : '0;
  assign wr_old      = mem_q[wr_word_q[IdxWidth-1:0]];

  always_comb begin
    amo_result = axi_req_i.w.data;  // plain write and swap
    if (is_atomic && atop_q != axi_types_pkg::ATOP_ATOMICSWAP) begin
      unique case (atop_q[2:0])
        axi_types_pkg::ATOP_ADD:  amo_result = wr_old + axi_req_i.w.data;
        axi_types_pkg::ATOP_CLR:  amo_result = wr_old & ~axi_req_i.w.data;
        axi_types_pkg::ATOP_EOR:  amo_result = wr_old ^ axi_req_i.w.data;
        axi_types_pkg::ATOP_SET:  amo_result = wr_old | axi_req_i.w.data;
        axi_types_pkg::ATOP_SMAX:
          amo_result = ($signed(wr_old) > $signed(axi_req_i.w.data)) ? wr_old : axi_req_i.w.data;
        axi_types_pkg::ATOP_SMIN:
          amo_result = ($signed(wr_old) < $signed(axi_req_i.w.data)) ? wr_old : axi_req_i.w.data;
        axi_types_pkg::ATOP_UMAX:
          amo_result = (wr_old > axi_req_i.w.data) ? wr_old : axi_req_i.w.data;
        axi_types_pkg::ATOP_UMIN:
          amo_result = (wr_old < axi_req_i.w.data) ? wr_old : axi_req_i.w.data;
      endcase
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (axi_req_i.ar_valid)      state_d = READ;
        else if (axi_req_i.aw_valid) state_d = WAIT_W;
      end
      READ:        if (r_hs && rd_last) state_d = IDLE;
      WAIT_W:      if (w_hs) state_d = is_atomic ? ATOMIC_RESP : WRITE_RESP;
      WRITE_RESP:  if (b_hs) state_d = IDLE;
      ATOMIC_RESP: if ((!r_pend_q || r_hs) && (!b_pend_q || b_hs)) state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      beat_cnt_q <= '0;
      r_pend_q   <= 1'b0;
      b_pend_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (ar_hs)                          beat_cnt_q <= '0;
      else if (r_hs && state_q == READ) beat_cnt_q <= beat_cnt_q + 1'b1;
      if (w_hs) begin
        r_pend_q <= is_atomic;
        b_pend_q <= 1'b1;
      end else begin
        if (r_hs) r_pend_q <= 1'b0;
        if (b_hs) b_pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rd_word_q <= axi_req_i.ar.addr[axi_types_pkg::AddrWidth-1:OffsetWidth];
      rd_len_q  <= axi_req_i.ar.len;
    end else if (r_hs && state_q == READ) begin
      rd_word_q <= rd_word_q + 1'b1;  // next word of the burst
    end
    if (aw_hs) begin
      wr_word_q <= axi_req_i.aw.addr[axi_types_pkg::AddrWidth-1:OffsetWidth];
      atop_q    <= axi_req_i.aw.atop;
    end
    if (w_hs) begin
      old_q <= wr_in_range ? wr_old : '0;
      err_q <= ~wr_in_range;
    end
    if (w_hs && wr_in_range) begin
      for (int unsigned i = 0; i < axi_types_pkg::StrbWidth; i++) begin
        if (axi_req_i.w.strb[i]) mem_q[wr_word_q[IdxWidth-1:0]][8*i +: 8] <= amo_result[8*i +: 8];
      end
    end
  end

  assign axi_resp_o.ar_ready = (state_q == IDLE);
  assign axi_resp_o.aw_ready = (state_q == IDLE) & ~axi_req_i.ar_valid;
  assign axi_resp_o.w_ready  = (state_q == WAIT_W);

  assign axi_resp_o.r_valid  = (state_q == READ) | r_pend_q;
  assign axi_resp_o.r.data   = (state_q == ATOMIC_RESP) ? old_q : rd_data;
  assign axi_resp_o.r.last   = (state_q == ATOMIC_RESP) | rd_last;
  assign axi_resp_o.r.resp   = ((state_q == ATOMIC_RESP) ? err_q : ~rd_in_range)
                             ? axi_types_pkg::RESP_SLVERR : axi_types_pkg::RESP_OKAY;

  assign axi_resp_o.b_valid  = b_pend_q;
  assign axi_resp_o.b.resp   = err_q ? axi_types_pkg::RESP_SLVERR : axi_types_pkg::RESP_OKAY;

endmodule

`default_nettype wire

/* logic/amo_mem_top.sv */
/*
 * Top level of the memory subsystem.
 * Joins the core-to-AXI adapter and the atomic AXI memory and sets the
 * write buffer depth and memory size. Only the core-side port is exposed.
 */
`default_nettype none
`timescale 1ns/10ps

module amo_mem_top #(
  parameter int unsigned WriteDepth = 2,
  parameter int unsigned MemWords   = 256
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  core_mem_pkg::core_req_t core_req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output core_mem_pkg::core_rsp_t core_rsp_o,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i
);

  axi_types_pkg::axi_req_t  axi_req;   // adapter to memory
  axi_types_pkg::axi_resp_t axi_resp;  // memory to adapter

  core_axi_adapter #(
    .WriteDepth ( WriteDepth )
  ) i_core_axi_adapter (
    .clk_i,
    .rst_i,
    .core_req_i,
    .req_valid_i,
    .req_ready_o,
    .core_rsp_o,
    .rsp_valid_o,
    .rsp_ready_i,
    .axi_req_o  ( axi_req    ),
    .axi_resp_i ( axi_resp   )
  );

  axi_atomic_mem #(
    .MemWords   ( MemWords   )
  ) i_axi_atomic_mem (
    .clk_i,
    .rst_i,
    .axi_req_i  ( axi_req    ),
    .axi_resp_o ( axi_resp   )
  );

endmodule

`default_nettype wire

/* dv/tb_amo_mem.sv */
/*
 * Directed testbench for the AMO memory subsystem.
 * Drives loads, stores and AMOs through the core-side port only and checks
 * each response against a reference memory array kept in the testbench.
 * Run through the Makefile in the project root.
 */
`default_nettype none
`timescale 1ns/10ps

module tb_amo_mem;

  localparam int unsigned ClkPeriod  = 40;
  localparam int unsigned ResetCycles = 16;
  localparam int unsigned MemWords   = 256;
  localparam int unsigned NumTests   = 6;
  localparam int unsigned TestCycles = 400;  // generous bound per test
  localparam int unsigned WaitCycles = 50;   // bound on a single handshake

  logic                    clk;
  logic                    rst;
  core_mem_pkg::core_req_t core_req;
  logic                    req_valid;
  logic                    req_ready;
  core_mem_pkg::core_rsp_t core_rsp;
  logic                    rsp_valid;
  logic                    rsp_ready;

  logic [31:0] ref_mem [MemWords];  // expected memory contents
  logic [31:0] lfsr_state = 32'h2cc30a34;

  amo_mem_top #(
    .WriteDepth  ( 2         ),
    .MemWords    ( MemWords  )
  ) i_amo_mem_top (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .core_req_i  ( core_req  ),
    .req_valid_i ( req_valid ),
    .req_ready_o ( req_ready ),
    .core_rsp_o  ( core_rsp  ),
    .rsp_valid_o ( rsp_valid ),
    .rsp_ready_i ( rsp_ready )
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // galois form, taps 32 30 26 25
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w          = {lfsr_state[0], w[31:1]};  // one step per bit
      lfsr_state = lfsr_step(lfsr_state);
    end
    return w;
  endfunction

  // RISC-V AMO result as seen by the core
  function automatic logic [31:0] amo_expect(input core_mem_pkg::amo_op_t op,
                                             input logic [31:0] old_val,
                                             input logic [31:0] operand);
    case (op)
      core_mem_pkg::ADD:  return old_val + operand;
      core_mem_pkg::AND:  return old_val & operand;
      core_mem_pkg::OR:   return old_val | operand;
      core_mem_pkg::XOR:  return old_val ^ operand;
      core_mem_pkg::MAX:  return ($signed(old_val) > $signed(operand)) ? old_val : operand;
      core_mem_pkg::MIN:  return ($signed(old_val) < $signed(operand)) ? old_val : operand;
      core_mem_pkg::MAXU: return (old_val > operand) ? old_val : operand;
      core_mem_pkg::MINU: return (old_val < operand) ? old_val : operand;
      default:            return operand;  // swap
    endcase
  endfunction

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected %h, actual %h", test, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value check failed in %s", test);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("%s did not complete within %0d cycles", what, WaitCycles);
    $display("STATUS: FAIL");
    $fatal(1, "handshake timeout");
  endtask

  // called right after a rising edge, returns on the edge of acceptance
  task automatic send_req(input core_mem_pkg::core_req_t req);
    int unsigned waited;
    logic        accepted;
    waited    = 0;
    accepted  = 1'b0;
    core_req  <= req;
    req_valid <= 1'b1;
    while (!accepted) begin
      @(negedge clk);
      accepted = req_ready;
      @(posedge clk);
      waited++;
      if (!accepted && waited > WaitCycles) report_timeout("request acceptance");
    end
    req_valid <= 1'b0;
  endtask

  task automatic recv_beat(output core_mem_pkg::core_rsp_t rsp);
    int unsigned waited;
    logic        got;
    waited = 0;
    got    = 1'b0;
    rsp    = '0;
    while (!got) begin
      @(negedge clk);
      got = rsp_valid & rsp_ready;
      rsp = core_rsp;
      @(posedge clk);
      waited++;
      if (!got && waited > WaitCycles) report_timeout("response beat");
    end
  endtask

  task automatic do_store(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    core_mem_pkg::core_req_t req;
    req       = '0;
    req.addr  = addr;
    req.write = 1'b1;
    req.amo   = core_mem_pkg::NONE;
    req.data  = data;
    req.strb  = strb;
    send_req(req);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) ref_mem[addr[9:2]][8*b +: 8] = data[8*b +: 8];
    end
    repeat (4) begin  // a store must stay silent
      @(negedge clk);
      check_value("store_no_response", 32'd0, {31'd0, rsp_valid});
      @(posedge clk);
    end
  endtask

  task automatic load_check(input string test, input logic [31:0] addr,
                            input int unsigned beats);
    core_mem_pkg::core_req_t req;
    core_mem_pkg::core_rsp_t rsp;
    req      = '0;
    req.addr = addr;
    req.amo  = core_mem_pkg::NONE;
    req.rlen = 8'(beats - 1);
    send_req(req);
    for (int unsigned i = 0; i < beats; i++) begin
      recv_beat(rsp);
      check_value(test, ref_mem[int'(addr[9:2]) + i], rsp.data);
      check_value({test, "_last"}, {31'd0, i == beats - 1}, {31'd0, rsp.last});
      check_value({test, "_error"}, 32'd0, {31'd0, rsp.error});
    end
  endtask

  task automatic do_amo(input string test, input core_mem_pkg::amo_op_t op,
                        input logic [31:0] addr, input logic [31:0] operand);
    core_mem_pkg::core_req_t req;
    core_mem_pkg::core_rsp_t rsp;
    req       = '0;
    req.addr  = addr;
    req.write = 1'b1;
    req.amo   = op;
    req.data  = operand;
    req.strb  = 4'hF;
    send_req(req);
    recv_beat(rsp);
    check_value({test, "_old"}, ref_mem[addr[9:2]], rsp.data);
    check_value({test, "_last"}, 32'd1, {31'd0, rsp.last});
    check_value({test, "_error"}, 32'd0, {31'd0, rsp.error});
    ref_mem[addr[9:2]] = amo_expect(op, ref_mem[addr[9:2]], operand);
  endtask

  task automatic test_store_load();
    do_store(32'h14, rand_word(), 4'hF);
    load_check("store_load", 32'h14, 1);
  endtask

  task automatic test_partial_strobe();
    do_store(32'h20, rand_word(), 4'hF);
    do_store(32'h20, rand_word(), 4'b0101);  // bytes 0 and 2 only
    load_check("partial_strobe", 32'h20, 1);
  endtask

  task automatic test_burst_read();
    for (int i = 0; i < 4; i++) do_store(32'h40 + 4 * i, rand_word(), 4'hF);
    load_check("burst_read", 32'h40, 4);
  endtask

  task automatic test_atomics();
    core_mem_pkg::amo_op_t ops [9];
    logic [31:0]           addr;
    ops = '{core_mem_pkg::SWAP, core_mem_pkg::ADD, core_mem_pkg::AND,
            core_mem_pkg::OR, core_mem_pkg::XOR, core_mem_pkg::MAX,
            core_mem_pkg::MAXU, core_mem_pkg::MIN, core_mem_pkg::MINU};
    for (int i = 0; i < 9; i++) begin
      addr = 32'h80 + 4 * i;
      do_store(addr, rand_word(), 4'hF);
      do_amo($sformatf("atomic_%s", ops[i].name()), ops[i], addr, rand_word());
      load_check($sformatf("atomic_%s_result", ops[i].name()), addr, 1);
    end
  endtask

  task automatic test_error();
    core_mem_pkg::core_req_t req;
    core_mem_pkg::core_rsp_t rsp;
    do_store(32'h0, rand_word(), 4'hF);  // word 0 shares low index bits with the bad address
    req      = '0;
    req.addr = 4 * MemWords;
    req.amo  = core_mem_pkg::NONE;
    send_req(req);
    recv_beat(rsp);
    check_value("error_load", 32'd1, {31'd0, rsp.error});
    check_value("error_load_last", 32'd1, {31'd0, rsp.last});
    req.write = 1'b1;
    req.amo   = core_mem_pkg::ADD;
    req.data  = rand_word();
    req.strb  = 4'hF;
    send_req(req);
    recv_beat(rsp);
    check_value("error_amo", 32'd1, {31'd0, rsp.error});
    load_check("error_mem_unchanged", 32'h0, 1);
  endtask

  task automatic test_backpressure();
    core_mem_pkg::core_req_t req;
    core_mem_pkg::core_rsp_t held;
    for (int i = 0; i < 4; i++) do_store(32'hC0 + 4 * i, rand_word(), 4'hF);
    req       = '0;
    req.addr  = 32'hC0;
    req.amo   = core_mem_pkg::NONE;
    req.rlen  = 8'd3;
    rsp_ready <= 1'b0;
    send_req(req);
    held = '0;
    for (int beat = 0; beat < 4; beat++) begin
      for (int stall = 0; stall < 3; stall++) begin
        @(negedge clk);
        check_value("backpressure_valid", 32'd1, {31'd0, rsp_valid});
        if (stall == 0) begin
          held = core_rsp;  // first look at this beat
        end else begin
          check_value("backpressure_hold_data", held.data, core_rsp.data);
          check_value("backpressure_hold_flags", {30'd0, held.error, held.last},
                      {30'd0, core_rsp.error, core_rsp.last});
        end
        @(posedge clk);
      end
      rsp_ready <= 1'b1;
      @(negedge clk);
      check_value("backpressure_hold_data", held.data, core_rsp.data);
      check_value("backpressure_hold_flags", {30'd0, held.error, held.last},
                  {30'd0, core_rsp.error, core_rsp.last});
      check_value("backpressure_data", ref_mem[48 + beat], core_rsp.data);
      check_value("backpressure_last", {31'd0, beat == 3}, {31'd0, core_rsp.last});
      check_value("backpressure_error", 32'd0, {31'd0, core_rsp.error});
      @(posedge clk);
      rsp_ready <= 1'b0;
    end
    rsp_ready <= 1'b1;
    @(negedge clk);
    check_value("backpressure_extra_beat", 32'd0, {31'd0, rsp_valid});
    @(posedge clk);
  endtask

  initial begin
    repeat (ResetCycles + NumTests * TestCycles) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    core_req  = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_value("reset_idle", 32'd0, {30'd0, req_ready, rsp_valid});
    @(posedge clk);
    test_store_load();
    test_partial_strobe();
    test_burst_read();
    test_atomics();
    test_error();
    test_backpressure();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
logic/axi_types_pkg.sv
logic/core_mem_pkg.sv
logic/write_buffer.sv
logic/core_axi_adapter.sv
logic/axi_atomic_mem.sv
logic/amo_mem_top.sv
dv/tb_amo_mem.sv

/* Makefile */
SIM  := obj_dir/Vtb_amo_mem
SRCS := $(shell cat build.f)

.PHONY: all run clean

all: run

$(SIM): build.f $(SRCS)
	verilator --binary -Wno-fatal --top-module tb_amo_mem -f build.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir
